//--- design/mm_pkg.sv
/* Built at one fixed size. Widths of the index and count types follow the sizes below.
   Arithmetic is signed integer and wraps at 32 bits. */
package mm_pkg;

  // Array and job sizes
  localparam int unsigned ARRAY_ROWS  = 4;
  localparam int unsigned ARRAY_DEPTH = 4;
  localparam int unsigned NUM_COLS    = 4;
  localparam int unsigned MAX_TILES   = 4;

  // Data widths
  localparam int unsigned ELEM_W = 16;
  localparam int unsigned ACC_W  = 32;

  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  typedef logic [$clog2(NUM_COLS)-1:0]      col_idx_t;
  typedef logic [$clog2(ARRAY_ROWS)-1:0]    row_idx_t;
  // Holds the number of tiles minus one
  typedef logic [$clog2(MAX_TILES)-1:0]     tile_cnt_t;
  // Counts the ARRAY_DEPTH+1 drain cycles
  typedef logic [$clog2(ARRAY_DEPTH+1)-1:0] drain_cnt_t;

  // One X row and one M column slice, element 0 in the low bits
  typedef elem_t [ARRAY_DEPTH-1:0] x_row_t;
  typedef elem_t [ARRAY_DEPTH-1:0] w_col_t;
  // One column of bias, partial sums or Z
  typedef acc_t  [ARRAY_ROWS-1:0]  bias_col_t;

  // Column handed from the feeder to the engine
  typedef struct packed {
    logic      valid;
    logic      first;
    col_idx_t  col;
    w_col_t    w;
    bias_col_t bias;
  } feed_t;

  // Finished column leaving the engine
  typedef struct packed {
    logic      valid;
    col_idx_t  col;
    bias_col_t z;
  } result_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_X,
    STREAM_M,
    DRAIN,
    EMIT
  } ctrl_state_e;

endpackage : mm_pkg

//--- design/mm_operand_feeder.sv
/* X tile storage has no reset and must be loaded before columns are streamed.
   The fed column is held for one cycle only. */
module mm_operand_feeder (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic                                     x_we_i,
  input  mm_pkg::row_idx_t                         x_row_idx_i,
  input  mm_pkg::x_row_t                           x_row_i,
  input  logic                                     m_take_i,
  input  mm_pkg::w_col_t                           m_col_i,
  input  mm_pkg::bias_col_t                        y_col_i,
  input  mm_pkg::col_idx_t                         feed_col_i,
  input  logic                                     feed_first_i,
  output mm_pkg::x_row_t [mm_pkg::ARRAY_ROWS-1:0]  x_tile_o,
  output mm_pkg::feed_t                            feed_o
);
  import mm_pkg::*;

  x_row_t [ARRAY_ROWS-1:0] x_tile_q;

  logic      feed_valid_q;
  logic      feed_first_q;
  col_idx_t  feed_col_q;
  w_col_t    feed_w_q;
  bias_col_t feed_bias_q;

  // One X row per write strobe
  always_ff @(posedge clk_i) begin
    if (x_we_i) begin
      x_tile_q[x_row_idx_i] <= x_row_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      feed_valid_q <= 1'b0;
    end else begin
      feed_valid_q <= m_take_i;
    end
  end

  // Column payload with its tags
  always_ff @(posedge clk_i) begin
    if (m_take_i) begin
      feed_first_q <= feed_first_i;
      feed_col_q   <= feed_col_i;
      feed_w_q     <= m_col_i;
      feed_bias_q  <= y_col_i;
    end
  end

  assign x_tile_o = x_tile_q;

  always_comb begin
    feed_o.valid = feed_valid_q;
    feed_o.first = feed_first_q;
    feed_o.col   = feed_col_q;
    feed_o.w     = feed_w_q;
    feed_o.bias  = feed_bias_q;
  end

  // Controller never loads X while a column is being taken
  a_no_write_during_take: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(x_we_i && m_take_i));

endmodule : mm_operand_feeder

//--- design/mm_mac_row.sv
/* Latency is ARRAY_DEPTH cycles from bias and weights to z_o. x_row_i must stay
   stable while a column is in flight. */
module mm_mac_row (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  mm_pkg::x_row_t x_row_i,
  input  mm_pkg::w_col_t w_i,
  input  mm_pkg::acc_t   bias_i,
  output mm_pkg::acc_t   z_o
);
  import mm_pkg::*;

  // Running sum after each stage
  acc_t  [ARRAY_DEPTH-1:0] sum_q;
  // Weight of each stage, delayed to meet its own sum
  elem_t [ARRAY_DEPTH-1:0] w_skew;

  for (genvar k = 0; k < ARRAY_DEPTH; k++) begin : gen_stage
    acc_t prod;
    acc_t addend;

    if (k == 0) begin : gen_direct
      assign w_skew[k] = w_i[k];
    end else begin : gen_delay
      // Stage k sees its weight k cycles late
      elem_t [k-1:0] dly_q;

      always_ff @(posedge clk_i) begin
        dly_q[0] <= w_i[k];
        for (int j = 1; j < k; j++) begin
          dly_q[j] <= dly_q[j-1];
        end
      end

      assign w_skew[k] = dly_q[k-1];
    end

    // Operands are sign-extended to the accumulator width
    assign prod = $signed(x_row_i[k]) * $signed(w_skew[k]);

    if (k == 0) begin : gen_first_add
      assign addend = bias_i;
    end else begin : gen_chain_add
      assign addend = sum_q[k-1];
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        sum_q[k] <= '0;
      end else begin
        sum_q[k] <= addend + prod;
      end
    end
  end

  assign z_o = sum_q[ARRAY_DEPTH-1];

endmodule : mm_mac_row

//--- design/mm_engine.sv
/* Accepts one column per cycle with no stall. The feedback read is combinational
   and is consumed in the same cycle as the feed. */
module mm_engine (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  mm_pkg::x_row_t [mm_pkg::ARRAY_ROWS-1:0]  x_tile_i,
  input  mm_pkg::feed_t                            feed_i,
  output mm_pkg::col_idx_t                         fb_col_o,
  input  mm_pkg::bias_col_t                        fb_z_i,
  output mm_pkg::result_t                          result_o
);
  import mm_pkg::*;

  bias_col_t row_bias;
  bias_col_t row_z;

  // Valid and column tag travel alongside the rows
  logic     [ARRAY_DEPTH-1:0] valid_q;
  col_idx_t [ARRAY_DEPTH-1:0] col_q;

  assign fb_col_o = feed_i.col;

  for (genvar r = 0; r < ARRAY_ROWS; r++) begin : gen_rows
    // Y on the first tile, the stored partial sum afterwards
    always_comb begin
      if (feed_i.first) begin
        row_bias[r] = feed_i.bias[r];
      end else begin
        row_bias[r] = fb_z_i[r];
      end
    end

    mm_mac_row i_row (
      .clk_i    ( clk_i        ),
      .arst_n_i ( arst_n_i     ),
      .x_row_i  ( x_tile_i[r]  ),
      .w_i      ( feed_i.w     ),
      .bias_i   ( row_bias[r]  ),
      .z_o      ( row_z[r]     )
    );
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[ARRAY_DEPTH-2:0], feed_i.valid};
    end
  end

  always_ff @(posedge clk_i) begin
    col_q <= {col_q[ARRAY_DEPTH-2:0], feed_i.col};
  end

  always_comb begin
    result_o.valid = valid_q[ARRAY_DEPTH-1];
    result_o.col   = col_q[ARRAY_DEPTH-1];
    result_o.z     = row_z;
  end

  // A feedback read never races a pending write to its own column
  a_no_feedback_hazard: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(feed_i.valid && !feed_i.first && result_o.valid && result_o.col == feed_i.col));

endmodule : mm_engine

//--- design/mm_result_store.sv
/* Partial sums have no reset; a job's first tile overwrites every column.
   Emit and result writes must not overlap. */
module mm_result_store (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  mm_pkg::result_t   result_i,
  input  mm_pkg::col_idx_t  fb_col_i,
  output mm_pkg::bias_col_t fb_z_o,
  input  logic              emit_i,
  input  mm_pkg::col_idx_t  emit_col_i,
  input  logic              emit_last_i,
  output logic              z_valid_o,
  output mm_pkg::bias_col_t z_col_o,
  output logic              done_o
);
  import mm_pkg::*;

  bias_col_t [NUM_COLS-1:0] part_q;
  bias_col_t                z_col_q;
  logic                     z_valid_q;
  logic                     done_q;

  always_ff @(posedge clk_i) begin
    if (result_i.valid) begin
      part_q[result_i.col] <= result_i.z;
    end
  end

  // Feedback read for the next tile
  assign fb_z_o = part_q[fb_col_i];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      z_valid_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      z_valid_q <= emit_i;
      done_q    <= emit_i && emit_last_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (emit_i) begin
      z_col_q <= part_q[emit_col_i];
    end
  end

  assign z_valid_o = z_valid_q;
  assign z_col_o   = z_col_q;
  assign done_o    = done_q;

  // Drain must finish all writes before emit starts
  a_no_emit_during_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(emit_i && result_i.valid));

endmodule : mm_result_store

//--- design/mm_ctrl.sv
/* Strobes outside their expected state are ignored. The host must send X rows and
   M columns in order; there is no back-pressure. */
module mm_ctrl (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              start_i,
  input  mm_pkg::tile_cnt_t tiles_i,
  input  logic              x_valid_i,
  input  logic              m_valid_i,
  output logic              x_we_o,
  output mm_pkg::row_idx_t  x_row_idx_o,
  output logic              m_take_o,
  output mm_pkg::col_idx_t  feed_col_o,
  output logic              feed_first_o,
  output logic              emit_o,
  output mm_pkg::col_idx_t  emit_col_o,
  output logic              emit_last_o,
  output logic              busy_o
);
  import mm_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  row_idx_t   row_cnt_q;
  // Shared by STREAM_M and EMIT
  col_idx_t   col_cnt_q;
  drain_cnt_t drain_cnt_q;
  tile_cnt_t  tile_q;
  tile_cnt_t  tiles_q;
  logic       busy_q;

  logic row_last;
  logic col_last;
  logic drain_last;
  logic tile_last;

  assign row_last   = row_cnt_q == row_idx_t'(ARRAY_ROWS - 1);
  assign col_last   = col_cnt_q == col_idx_t'(NUM_COLS - 1);
  assign drain_last = drain_cnt_q == drain_cnt_t'(ARRAY_DEPTH);
  assign tile_last  = tile_q == tiles_q;

  assign x_we_o       = (state_q == LOAD_X) && x_valid_i;
  assign x_row_idx_o  = row_cnt_q;
  assign m_take_o     = (state_q == STREAM_M) && m_valid_i;
  assign feed_col_o   = col_cnt_q;
  assign feed_first_o = tile_q == '0;
  assign emit_o       = state_q == EMIT;
  assign emit_col_o   = col_cnt_q;
  assign emit_last_o  = emit_o && col_last;
  assign busy_o       = busy_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (start_i) state_d = LOAD_X;
      LOAD_X:   if (x_we_o && row_last) state_d = STREAM_M;
      STREAM_M: if (m_take_o && col_last) state_d = DRAIN;
      // Last write of the tile lands on the final drain edge
      DRAIN:    if (drain_last) state_d = tile_last ? EMIT : LOAD_X;
      EMIT:     if (col_last) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= IDLE;
      row_cnt_q   <= '0;
      col_cnt_q   <= '0;
      drain_cnt_q <= '0;
      tile_q      <= '0;
      tiles_q     <= '0;
      busy_q      <= 1'b0;
    end else begin
      state_q <= state_d;

      if (state_q == IDLE && start_i) begin
        tiles_q   <= tiles_i;
        tile_q    <= '0;
        row_cnt_q <= '0;
        col_cnt_q <= '0;
        busy_q    <= 1'b1;
      end

      if (x_we_o) begin
        row_cnt_q <= row_last ? '0 : row_cnt_q + 1'b1;
      end

      if (m_take_o || emit_o) begin
        col_cnt_q <= col_last ? '0 : col_cnt_q + 1'b1;
      end

      if (state_q == DRAIN) begin
        drain_cnt_q <= drain_last ? '0 : drain_cnt_q + 1'b1;
        if (drain_last && !tile_last) begin
          tile_q <= tile_q + 1'b1;
        end
      end

      // Falls together with done_o
      if (emit_o && col_last) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule : mm_ctrl

//--- design/mm_top.sv
/* Computes Z = Y + X*M with K = ARRAY_DEPTH * (tiles_i + 1).
   The host drives plain strobes and the output cannot be stalled. */
module mm_top (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              start_i,
  input  mm_pkg::tile_cnt_t tiles_i,
  input  logic              x_valid_i,
  input  mm_pkg::x_row_t    x_row_i,
  input  logic              m_valid_i,
  input  mm_pkg::w_col_t    m_col_i,
  input  mm_pkg::bias_col_t y_col_i,
  output logic              busy_o,
  output logic              z_valid_o,
  output mm_pkg::bias_col_t z_col_o,
  output logic              done_o
);
  import mm_pkg::*;

  logic                    x_we;
  row_idx_t                x_row_idx;
  logic                    m_take;
  col_idx_t                feed_col;
  logic                    feed_first;
  logic                    emit;
  col_idx_t                emit_col;
  logic                    emit_last;
  x_row_t [ARRAY_ROWS-1:0] x_tile;
  feed_t                   feed;
  col_idx_t                fb_col;
  bias_col_t               fb_z;
  result_t                 result;

  mm_ctrl i_ctrl (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .start_i      ( start_i    ),
    .tiles_i      ( tiles_i    ),
    .x_valid_i    ( x_valid_i  ),
    .m_valid_i    ( m_valid_i  ),
    .x_we_o       ( x_we       ),
    .x_row_idx_o  ( x_row_idx  ),
    .m_take_o     ( m_take     ),
    .feed_col_o   ( feed_col   ),
    .feed_first_o ( feed_first ),
    .emit_o       ( emit       ),
    .emit_col_o   ( emit_col   ),
    .emit_last_o  ( emit_last  ),
    .busy_o       ( busy_o     )
  );

  mm_operand_feeder i_feeder (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .x_we_i       ( x_we       ),
    .x_row_idx_i  ( x_row_idx  ),
    .x_row_i      ( x_row_i    ),
    .m_take_i     ( m_take     ),
    .m_col_i      ( m_col_i    ),
    .y_col_i      ( y_col_i    ),
    .feed_col_i   ( feed_col   ),
    .feed_first_i ( feed_first ),
    .x_tile_o     ( x_tile     ),
    .feed_o       ( feed       )
  );

  mm_engine i_engine (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .x_tile_i ( x_tile   ),
    .feed_i   ( feed     ),
    .fb_col_o ( fb_col   ),
    .fb_z_i   ( fb_z     ),
    .result_o ( result   )
  );

  mm_result_store i_store (
    .clk_i       ( clk_i     ),
    .arst_n_i    ( arst_n_i  ),
    .result_i    ( result    ),
    .fb_col_i    ( fb_col    ),
    .fb_z_o      ( fb_z      ),
    .emit_i      ( emit      ),
    .emit_col_i  ( emit_col  ),
    .emit_last_i ( emit_last ),
    .z_valid_o   ( z_valid_o ),
    .z_col_o     ( z_col_o   ),
    .done_o      ( done_o    )
  );

endmodule : mm_top

//--- sim/tb_mm_top.sv
/* Runs a table of jobs on mm_top and checks Z against a wrapping 32-bit model.
   Inputs change 1 time unit after the rising edge and outputs are sampled on the falling edge. */
module tb_mm_top;
  import mm_pkg::*;

  localparam int unsigned K_MAX    = MAX_TILES * ARRAY_DEPTH;
  localparam int unsigned NUM_JOBS = 10;

  localparam logic [1:0] RANGE_SMALL   = 2'd0;
  localparam logic [1:0] RANGE_FULL    = 2'd1;
  localparam logic [1:0] RANGE_EXTREME = 2'd2;

  typedef struct packed {
    tile_cnt_t  tiles_m1;
    logic [1:0] range_sel;
    logic       zero_bias;
    logic       gaps;
    logic       idle_strobes;
    logic       abort;
  } job_t;

  // Tiles minus one, operand range, zero bias, gaps, strobes in IDLE, reset mid job
  localparam job_t JOBS [NUM_JOBS] = '{
    '{2'd0, RANGE_SMALL,   1'b0, 1'b0, 1'b0, 1'b0},
    '{2'd0, RANGE_FULL,    1'b0, 1'b1, 1'b0, 1'b0},
    '{2'd1, RANGE_SMALL,   1'b0, 1'b1, 1'b0, 1'b0},
    '{2'd2, RANGE_FULL,    1'b1, 1'b0, 1'b0, 1'b0},
    '{2'd3, RANGE_FULL,    1'b0, 1'b1, 1'b0, 1'b0},
    '{2'd3, RANGE_EXTREME, 1'b0, 1'b0, 1'b0, 1'b0},
    '{2'd1, RANGE_EXTREME, 1'b1, 1'b0, 1'b1, 1'b0},
    '{2'd2, RANGE_FULL,    1'b0, 1'b0, 1'b0, 1'b1},
    '{2'd0, RANGE_SMALL,   1'b0, 1'b1, 1'b0, 1'b0},
    '{2'd3, RANGE_EXTREME, 1'b0, 1'b1, 1'b1, 1'b0}
  };

  logic      clk_i;
  logic      arst_n_i;
  logic      start_i;
  tile_cnt_t tiles_i;
  logic      x_valid_i;
  x_row_t    x_row_i;
  logic      m_valid_i;
  w_col_t    m_col_i;
  bias_col_t y_col_i;
  logic      busy_o;
  logic      z_valid_o;
  bias_col_t z_col_o;
  logic      done_o;

  elem_t x_mat [ARRAY_ROWS][K_MAX];
  elem_t m_mat [K_MAX][NUM_COLS];
  acc_t  y_mat [ARRAY_ROWS][NUM_COLS];
  acc_t  z_exp [ARRAY_ROWS][NUM_COLS];

  // Filled by the output monitor
  bias_col_t z_q [$];
  int        done_cnt;
  int        done_idx;
  logic      busy_at_done;

  int err_cnt = 0;
  int job_cnt = 0;
  int job_fail_cnt = 0;
  int cycle_cnt = 0;
  int cycle_limit;

  mm_top mm_top_inst (
    .clk_i     ( clk_i     ),
    .arst_n_i  ( arst_n_i  ),
    .start_i   ( start_i   ),
    .tiles_i   ( tiles_i   ),
    .x_valid_i ( x_valid_i ),
    .x_row_i   ( x_row_i   ),
    .m_valid_i ( m_valid_i ),
    .m_col_i   ( m_col_i   ),
    .y_col_i   ( y_col_i   ),
    .busy_o    ( busy_o    ),
    .z_valid_o ( z_valid_o ),
    .z_col_o   ( z_col_o   ),
    .done_o    ( done_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (z_valid_o) begin
        z_q.push_back(z_col_o);
      end
      if (done_o) begin
        done_cnt     = done_cnt + 1;
        done_idx     = z_q.size();
        busy_at_done = busy_o;
      end
    end
  end

  function automatic int run_budget();
    int total;
    total = 100;
    for (int i = 0; i < NUM_JOBS; i++) begin
      total += (int'(JOBS[i].tiles_m1) + 1) * (ARRAY_ROWS + NUM_COLS + ARRAY_DEPTH + 4);
      total += NUM_COLS + 10;
    end
    return total;
  endfunction

  function automatic elem_t rand_elem(logic [1:0] range_sel);
    elem_t val;
    case (range_sel)
      RANGE_SMALL: val = elem_t'(int'($urandom_range(15, 0)) - 8);
      RANGE_FULL:  val = elem_t'($urandom());
      // Mostly the most negative value
      default:     val = ($urandom_range(3, 0) == 0) ? 16'sh7fff : 16'sh8000;
    endcase
    return val;
  endfunction

  function automatic acc_t rand_bias(logic [1:0] range_sel, logic zero_bias);
    acc_t val;
    if (zero_bias) begin
      val = '0;
    end else if (range_sel == RANGE_SMALL) begin
      val = acc_t'(int'($urandom_range(200, 0)) - 100);
    end else if (range_sel == RANGE_FULL) begin
      val = acc_t'($urandom());
    end else begin
      val = ($urandom_range(1, 0) == 0) ? 32'sh8000_0000 : 32'sh7fff_ffff;
    end
    return val;
  endfunction

  // Z = Y + X*M with sums that wrap at 32 bits
  function automatic void compute_expected(int n_tiles);
    int acc;
    for (int r = 0; r < ARRAY_ROWS; r++) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        acc = int'(y_mat[r][c]);
        for (int k = 0; k < n_tiles * ARRAY_DEPTH; k++) begin
          acc = acc + int'(x_mat[r][k]) * int'(m_mat[k][c]);
        end
        z_exp[r][c] = acc_t'(acc);
      end
    end
  endfunction

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic fill_operands(job_t job);
    for (int k = 0; k < K_MAX; k++) begin
      for (int r = 0; r < ARRAY_ROWS; r++) begin
        x_mat[r][k] = rand_elem(job.range_sel);
      end
      for (int c = 0; c < NUM_COLS; c++) begin
        m_mat[k][c] = rand_elem(job.range_sel);
      end
    end
    for (int r = 0; r < ARRAY_ROWS; r++) begin
      for (int c = 0; c < NUM_COLS; c++) begin
        y_mat[r][c] = rand_bias(job.range_sel, job.zero_bias);
      end
    end
  endtask

  task automatic load_tile(int t);
    x_row_t row;
    for (int r = 0; r < ARRAY_ROWS; r++) begin
      for (int k = 0; k < ARRAY_DEPTH; k++) begin
        row[k] = x_mat[r][t * ARRAY_DEPTH + k];
      end
      x_row_i   = row;
      x_valid_i = 1'b1;
      step();
    end
    x_valid_i = 1'b0;
  endtask

  task automatic stream_tile(int t, int n_cols, logic gaps);
    int        gap_col;
    w_col_t    col;
    bias_col_t bias;
    gap_col = gaps ? int'($urandom_range(NUM_COLS - 1, 0)) : -1;
    for (int c = 0; c < n_cols; c++) begin
      if (c == gap_col) begin
        m_valid_i = 1'b0;
        step();
      end
      for (int k = 0; k < ARRAY_DEPTH; k++) begin
        col[k] = m_mat[t * ARRAY_DEPTH + k][c];
      end
      // Y must be ignored after the first tile, so later tiles carry junk
      for (int r = 0; r < ARRAY_ROWS; r++) begin
        bias[r] = (t == 0) ? y_mat[r][c] : acc_t'($urandom());
      end
      m_col_i   = col;
      y_col_i   = bias;
      m_valid_i = 1'b1;
      step();
    end
    m_valid_i = 1'b0;
  endtask

  task automatic poke_idle_strobes(int idx);
    repeat (2) begin
      x_row_i   = {$urandom(), $urandom()};
      x_valid_i = 1'b1;
      step();
    end
    x_valid_i = 1'b0;
    repeat (2) begin
      m_col_i   = {$urandom(), $urandom()};
      y_col_i   = {$urandom(), $urandom(), $urandom(), $urandom()};
      m_valid_i = 1'b1;
      step();
    end
    m_valid_i = 1'b0;
    step();
    if (busy_o !== 1'b0 || z_q.size() != 0 || done_cnt != 0) begin
      $display("job %0d: strobes in IDLE started activity", idx);
      err_cnt++;
    end
  endtask

  task automatic reset_mid_job(int idx);
    arst_n_i = 1'b0;
    for (int i = 0; i <= 5; i++) begin
      if (i == 5) begin
        arst_n_i = 1'b1;
      end
      step();
      if (busy_o !== 1'b0 || z_valid_o !== 1'b0 || done_o !== 1'b0) begin
        $display("job %0d: outputs not low around reset (busy_o %b z_valid_o %b done_o %b)",
                 idx, busy_o, z_valid_o, done_o);
        err_cnt++;
      end
    end
    if (z_q.size() != 0 || done_cnt != 0) begin
      $display("job %0d: output pulses seen after reset", idx);
      err_cnt++;
    end
  endtask

  task automatic check_results(int idx);
    if (z_q.size() != NUM_COLS) begin
      $display("job %0d: expected %0d z_valid_o pulses, saw %0d", idx, NUM_COLS, z_q.size());
      err_cnt++;
    end
    // Columns come out in order, so queue position is the column
    for (int c = 0; c < NUM_COLS && c < z_q.size(); c++) begin
      for (int r = 0; r < ARRAY_ROWS; r++) begin
        if (z_q[c][r] !== z_exp[r][c]) begin
          $display("mismatch job %0d z_col_o col %0d row %0d: expected %h, actual %h",
                   idx, c, r, z_exp[r][c], z_q[c][r]);
          err_cnt++;
        end
      end
    end
    if (done_cnt == 0) begin
      $display("job %0d: done_o never pulsed", idx);
      err_cnt++;
    end else if (done_cnt > 1) begin
      $display("job %0d: done_o pulsed %0d times", idx, done_cnt);
      err_cnt++;
    end else if (done_idx != NUM_COLS) begin
      $display("job %0d: done_o did not come with the last z_valid_o", idx);
      err_cnt++;
    end
    if (done_cnt != 0 && busy_at_done !== 1'b0) begin
      $display("job %0d: busy_o still high when done_o pulsed", idx);
      err_cnt++;
    end
  endtask

  task automatic run_job(int idx);
    job_t job;
    int   n_tiles;
    int   errs_before;
    int   waited;
    job         = JOBS[idx];
    n_tiles     = int'(job.tiles_m1) + 1;
    errs_before = err_cnt;
    z_q.delete();
    done_cnt     = 0;
    done_idx     = -1;
    busy_at_done = 1'b0;
    fill_operands(job);
    compute_expected(n_tiles);
    if (job.idle_strobes) begin
      poke_idle_strobes(idx);
    end
    start_i = 1'b1;
    tiles_i = job.tiles_m1;
    step();
    start_i = 1'b0;
    if (busy_o !== 1'b1) begin
      $display("job %0d: busy_o did not rise after start_i", idx);
      err_cnt++;
    end
    if (job.abort) begin
      load_tile(0);
      stream_tile(0, NUM_COLS / 2, 1'b0);
      reset_mid_job(idx);
    end else begin
      for (int t = 0; t < n_tiles; t++) begin
        load_tile(t);
        stream_tile(t, NUM_COLS, job.gaps);
        // Drain before the next tile's X rows are accepted
        repeat (ARRAY_DEPTH + 1) step();
      end
      waited = 0;
      while (done_cnt == 0 && waited < NUM_COLS + ARRAY_DEPTH + 4) begin
        step();
        waited++;
      end
      // One more cycle to catch a stray z_valid_o
      step();
      check_results(idx);
    end
    job_cnt++;
    if (err_cnt == errs_before) begin
      $display("job %0d: %0d tiles ok", idx, n_tiles);
    end else begin
      job_fail_cnt++;
      $display("job %0d: %0d tiles failed with %0d errors", idx, n_tiles, err_cnt - errs_before);
    end
  endtask

  initial begin
    void'($urandom(32'h8505_25bf));
    cycle_limit = run_budget();
    arst_n_i    = 1'b0;
    start_i     = 1'b0;
    tiles_i     = '0;
    x_valid_i   = 1'b0;
    x_row_i     = '0;
    m_valid_i   = 1'b0;
    m_col_i     = '0;
    y_col_i     = '0;
    repeat (5) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    step();
    for (int i = 0; i < NUM_JOBS; i++) begin
      run_job(i);
    end
    $display("jobs %0d, failed jobs %0d, failed checks %0d", job_cnt, job_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_mm_top

//--- mm_array.f
design/mm_pkg.sv
design/mm_operand_feeder.sv
design/mm_mac_row.sv
design/mm_engine.sv
design/mm_result_store.sv
design/mm_ctrl.sv
design/mm_top.sv
sim/tb_mm_top.sv

//--- Makefile
TOP := tb_mm_top

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f mm_array.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
